// ==== design/rv64_alu.sv ====
`timescale 1ns/1ps

`include "rv64_exec_config.svh"

module rv64_alu (
    input  rv64_exec_pkg::dec_op_t i_op,
    input  rv64_exec_pkg::xdata_t  i_rs1_data,
    input  rv64_exec_pkg::xdata_t  i_rs2_data,
    input  rv64_exec_pkg::pc_t     i_pc,
    output rv64_exec_pkg::xdata_t  o_result
);

    rv64_exec_pkg::xdata_t op_a;
    rv64_exec_pkg::xdata_t op_b;
    rv64_exec_pkg::xdata_t sum;
    rv64_exec_pkg::xdata_t diff;
    rv64_exec_pkg::xdata_t res_d;
    rv64_exec_pkg::xdata_t res_w_ext;
    rv64_exec_pkg::word_t  a_w;
    rv64_exec_pkg::word_t  res_w;
    logic [5:0]            shamt_d;
    logic [4:0]            shamt_w;
    logic                  lt_s;
    logic                  lt_u;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operand select.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // pc as operand a only for auipc.
    assign op_a = i_op.use_pc_a ? i_pc : i_rs1_data;
    assign op_b = i_op.use_imm ? i_op.imm : i_rs2_data;

    // shared adder and compare.
    assign sum  = op_a + op_b;
    assign diff = op_a - op_b;
    assign lt_s = $signed(op_a) < $signed(op_b);
    assign lt_u = op_a < op_b;

    assign shamt_d = op_b[5:0];
    assign shamt_w = op_b[4:0];
    assign a_w     = op_a[31:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // 64-bit operations.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (i_op.alu_op)
            rv64_exec_pkg::ADD:    res_d = sum;
            rv64_exec_pkg::SUB:    res_d = diff;
            rv64_exec_pkg::SLL:    res_d = op_a << shamt_d;
            rv64_exec_pkg::SLT:    res_d = {{(`RV_XLEN-1){1'b0}}, lt_s};
            rv64_exec_pkg::SLTU:   res_d = {{(`RV_XLEN-1){1'b0}}, lt_u};
            rv64_exec_pkg::XOR:    res_d = op_a ^ op_b;
            rv64_exec_pkg::SRL:    res_d = op_a >> shamt_d;
            rv64_exec_pkg::SRA:    res_d = $signed(op_a) >>> shamt_d;
            rv64_exec_pkg::OR:     res_d = op_a | op_b;
            rv64_exec_pkg::AND:    res_d = op_a & op_b;
            rv64_exec_pkg::PASS_B: res_d = op_b;
            default:               res_d = sum;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // word operations.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // low half of the 64-bit adder is the word sum.
    always_comb begin
        case (i_op.alu_op)
            rv64_exec_pkg::SUB: res_w = diff[31:0];
            rv64_exec_pkg::SLL: res_w = a_w << shamt_w;
            rv64_exec_pkg::SRL: res_w = a_w >> shamt_w;
            rv64_exec_pkg::SRA: res_w = $signed(a_w) >>> shamt_w;
            default:            res_w = sum[31:0];
        endcase
    end

    assign res_w_ext = {{(`RV_XLEN-32){res_w[31]}}, res_w};

    assign o_result = i_op.word_mode ? res_w_ext : res_d;

endmodule

// ==== design/rv64_branch_unit.sv ====
`timescale 1ns/1ps

`include "rv64_exec_config.svh"

module rv64_branch_unit (
    input  rv64_exec_pkg::dec_op_t i_op,
    input  rv64_exec_pkg::xdata_t  i_rs1_data,
    input  rv64_exec_pkg::xdata_t  i_rs2_data,
    input  rv64_exec_pkg::pc_t     i_pc,
    output rv64_exec_pkg::pc_t     o_next_pc,
    output rv64_exec_pkg::xdata_t  o_link
);

    logic                  eq;
    logic                  lt_s;
    logic                  lt_u;
    logic                  taken;
    rv64_exec_pkg::pc_t    seq_pc;
    rv64_exec_pkg::pc_t    br_target;
    rv64_exec_pkg::xdata_t jalr_sum;
    rv64_exec_pkg::pc_t    jalr_target;

    assign eq   = (i_rs1_data == i_rs2_data);
    assign lt_s = $signed(i_rs1_data) < $signed(i_rs2_data);
    assign lt_u = i_rs1_data < i_rs2_data;

    always_comb begin
        case (i_op.br_cond)
            rv64_exec_pkg::EQ:     taken = eq;
            rv64_exec_pkg::NE:     taken = !eq;
            rv64_exec_pkg::LT:     taken = lt_s;
            rv64_exec_pkg::GE:     taken = !lt_s;
            rv64_exec_pkg::LTU:    taken = lt_u;
            rv64_exec_pkg::GEU:    taken = !lt_u;
            rv64_exec_pkg::ALWAYS: taken = 1'b1;
            default:               taken = 1'b0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // targets.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign seq_pc    = i_pc + rv64_exec_pkg::pc_t'(`RV_PC_STEP);
    assign br_target = i_pc + i_op.imm;

    // jalr drops bit 0 of the sum.
    assign jalr_sum    = i_rs1_data + i_op.imm;
    assign jalr_target = {jalr_sum[`RV_XLEN-1:1], 1'b0};

    assign o_link    = seq_pc;
    assign o_next_pc = i_op.is_jalr ? jalr_target :
                       taken        ? br_target   : seq_pc;

endmodule

// ==== design/rv64_decoder.sv ====
`timescale 1ns/1ps

`include "rv64_exec_config.svh"

module rv64_decoder (
    input  rv64_exec_pkg::instr_t  i_instr,
    output rv64_exec_pkg::dec_op_t o_op
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic                  rr_f7_bad;
    logic                  sh64_bad;
    logic                  w_f3_ok;
    rv64_exec_pkg::xdata_t imm_i;
    rv64_exec_pkg::xdata_t imm_b;
    rv64_exec_pkg::xdata_t imm_u;
    rv64_exec_pkg::xdata_t imm_j;

    function automatic rv64_exec_pkg::alu_op_e alu_from_f3(input logic [2:0] f3,
                                                           input logic       alt);
        rv64_exec_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = alt ? rv64_exec_pkg::SUB : rv64_exec_pkg::ADD;
            3'b001:  op = rv64_exec_pkg::SLL;
            3'b010:  op = rv64_exec_pkg::SLT;
            3'b011:  op = rv64_exec_pkg::SLTU;
            3'b100:  op = rv64_exec_pkg::XOR;
            3'b101:  op = alt ? rv64_exec_pkg::SRA : rv64_exec_pkg::SRL;
            3'b110:  op = rv64_exec_pkg::OR;
            default: op = rv64_exec_pkg::AND;
        endcase
        return op;
    endfunction

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    assign imm_i = {{(`RV_XLEN-12){i_instr[31]}}, i_instr[31:20]};
    assign imm_b = {{(`RV_XLEN-12){i_instr[31]}}, i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {{(`RV_XLEN-32){i_instr[31]}}, i_instr[31:12], 12'b0};
    assign imm_j = {{(`RV_XLEN-20){i_instr[31]}}, i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    // alternate funct7 only for sub and sra.
    assign rr_f7_bad = !((funct7 == 7'b0000000) ||
                         (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
    // rv64 immediate shifts carry a 6-bit shamt under funct6.
    assign sh64_bad  = (funct3 == 3'b001) ? (i_instr[31:26] != 6'b000000) :
                       (funct3 == 3'b101) ? !(i_instr[31:26] == 6'b000000 ||
                                              i_instr[31:26] == 6'b010000) : 1'b0;
    assign w_f3_ok   = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b101);

    always_comb begin
        o_op         = '0;
        o_op.rs1     = i_instr[19:15];
        o_op.rs2     = i_instr[24:20];
        o_op.rd      = i_instr[11:7];
        o_op.alu_op  = rv64_exec_pkg::ADD;
        o_op.br_cond = rv64_exec_pkg::NONE;
        o_op.imm     = imm_i;
        case (opcode)
            rv64_exec_pkg::OP: begin
                o_op.alu_op    = alu_from_f3(funct3, funct7[5]);
                o_op.writes_rd = 1'b1;
                o_op.illegal   = rr_f7_bad;
            end
            rv64_exec_pkg::OP_IMM: begin
                o_op.alu_op    = alu_from_f3(funct3, funct3 == 3'b101 && i_instr[30]);
                o_op.use_imm   = 1'b1;
                o_op.writes_rd = 1'b1;
                o_op.illegal   = sh64_bad;
            end
            rv64_exec_pkg::OP_32: begin
                o_op.alu_op    = alu_from_f3(funct3, funct7[5]);
                o_op.word_mode = 1'b1;
                o_op.writes_rd = 1'b1;
                o_op.illegal   = rr_f7_bad || !w_f3_ok;
            end
            rv64_exec_pkg::OP_IMM_32: begin
                o_op.alu_op    = alu_from_f3(funct3, funct3 == 3'b101 && i_instr[30]);
                o_op.use_imm   = 1'b1;
                o_op.word_mode = 1'b1;
                o_op.writes_rd = 1'b1;
                // shamt bit 5 set falls out as a bad funct7.
                o_op.illegal   = !w_f3_ok || (funct3 != 3'b000 && rr_f7_bad);
            end
            rv64_exec_pkg::LUI: begin
                o_op.alu_op    = rv64_exec_pkg::PASS_B;
                o_op.use_imm   = 1'b1;
                o_op.imm       = imm_u;
                o_op.writes_rd = 1'b1;
            end
            rv64_exec_pkg::AUIPC: begin
                o_op.use_imm   = 1'b1;
                o_op.use_pc_a  = 1'b1;
                o_op.imm       = imm_u;
                o_op.writes_rd = 1'b1;
            end
            rv64_exec_pkg::JAL: begin
                o_op.br_cond   = rv64_exec_pkg::ALWAYS;
                o_op.imm       = imm_j;
                o_op.writes_rd = 1'b1;
            end
            rv64_exec_pkg::JALR: begin
                o_op.br_cond   = rv64_exec_pkg::ALWAYS;
                o_op.is_jalr   = 1'b1;
                o_op.writes_rd = 1'b1;
                o_op.illegal   = (funct3 != 3'b000);
            end
            rv64_exec_pkg::BRANCH: begin
                o_op.imm = imm_b;
                case (funct3)
                    3'b000:  o_op.br_cond = rv64_exec_pkg::EQ;
                    3'b001:  o_op.br_cond = rv64_exec_pkg::NE;
                    3'b100:  o_op.br_cond = rv64_exec_pkg::LT;
                    3'b101:  o_op.br_cond = rv64_exec_pkg::GE;
                    3'b110:  o_op.br_cond = rv64_exec_pkg::LTU;
                    3'b111:  o_op.br_cond = rv64_exec_pkg::GEU;
                    default: o_op.illegal = 1'b1;
                endcase
            end
            default: o_op.illegal = 1'b1;
        endcase
        // an illegal word falls through to the next sequential pc.
        if (o_op.illegal) begin
            o_op.writes_rd = 1'b0;
            o_op.br_cond   = rv64_exec_pkg::NONE;
            o_op.is_jalr   = 1'b0;
        end
    end

endmodule

// ==== design/rv64_exec_config.svh ====
`ifndef RV64_EXEC_CONFIG_SVH
`define RV64_EXEC_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage sizing.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// data path width.
`define RV_XLEN 64

// instruction word width.
`define RV_ILEN 32

// architectural integer registers.
`define RV_NREGS 32

// sequential pc increment.
`define RV_PC_STEP 4

`endif

// ==== design/rv64_exec_pkg.sv ====
`include "rv64_exec_config.svh"

package rv64_exec_pkg;

    typedef logic [`RV_XLEN-1:0]          xdata_t;
    typedef logic [31:0]                  word_t;
    typedef logic [$clog2(`RV_NREGS)-1:0] reg_addr_t;
    typedef logic [`RV_XLEN-1:0]          pc_t;
    typedef logic [`RV_ILEN-1:0]          instr_t;

    // major opcodes handled by the stage.
    typedef enum logic [6:0] {
        OP        = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_32     = 7'b0111011,
        OP_IMM_32 = 7'b0011011,
        LUI       = 7'b0110111,
        AUIPC     = 7'b0010111,
        JAL       = 7'b1101111,
        JALR      = 7'b1100111,
        BRANCH    = 7'b1100011
    } major_op_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        NONE, EQ, NE, LT, GE, LTU, GEU, ALWAYS
    } br_cond_e;

    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        alu_op_e   alu_op;
        br_cond_e  br_cond;
        logic      use_imm;
        logic      use_pc_a;
        logic      word_mode;
        logic      is_jalr;
        logic      writes_rd;
        logic      illegal;
        xdata_t    imm;
    } dec_op_t;

    typedef struct packed {
        logic      valid;
        logic      we;
        reg_addr_t rd;
        xdata_t    data;
        pc_t       next_pc;
    } wb_t;

endpackage

// ==== design/rv64_exec_unit.sv ====
`timescale 1ns/1ps

module rv64_exec_unit (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic                      i_valid,
    input  rv64_exec_pkg::instr_t     i_instr,
    input  rv64_exec_pkg::pc_t        i_pc,
    output logic                      o_wb_valid,
    output logic                      o_wb_we,
    output logic                      o_wb_illegal,
    output rv64_exec_pkg::reg_addr_t  o_wb_rd,
    output rv64_exec_pkg::xdata_t     o_wb_data,
    output rv64_exec_pkg::pc_t        o_next_pc
);

    rv64_exec_pkg::dec_op_t dec_op;
    rv64_exec_pkg::xdata_t  rs1_data;
    rv64_exec_pkg::xdata_t  rs2_data;
    rv64_exec_pkg::xdata_t  alu_result;
    rv64_exec_pkg::xdata_t  link;
    rv64_exec_pkg::xdata_t  wr_data;
    rv64_exec_pkg::pc_t     next_pc;
    logic                   wr_en;
    rv64_exec_pkg::wb_t     wb_q;
    logic                   illegal_q;

    rv64_decoder rv64_decoder_i (
        .i_instr (i_instr),
        .o_op    (dec_op)
    );

    // jumps write the return address.
    assign wr_en   = i_valid && dec_op.writes_rd && !dec_op.illegal;
    assign wr_data = (dec_op.br_cond == rv64_exec_pkg::ALWAYS) ? link : alu_result;

    rv64_regfile rv64_regfile_i (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_rs1_addr (dec_op.rs1),
        .i_rs2_addr (dec_op.rs2),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_we       (wr_en),
        .i_wr_addr  (dec_op.rd),
        .i_wr_data  (wr_data)
    );

    rv64_alu rv64_alu_i (
        .i_op       (dec_op),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .i_pc       (i_pc),
        .o_result   (alu_result)
    );

    rv64_branch_unit rv64_branch_unit_i (
        .i_op       (dec_op),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .i_pc       (i_pc),
        .o_next_pc  (next_pc),
        .o_link     (link)
    );

    // write-back register, same edge as the regfile write.
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wb_q      <= '0;
            illegal_q <= 1'b0;
        end else begin
            wb_q.valid   <= i_valid;
            wb_q.we      <= wr_en;
            wb_q.rd      <= dec_op.rd;
            wb_q.data    <= wr_data;
            wb_q.next_pc <= next_pc;
            illegal_q    <= i_valid && dec_op.illegal;
        end
    end

    assign o_wb_valid   = wb_q.valid;
    assign o_wb_we      = wb_q.we;
    assign o_wb_illegal = illegal_q;
    assign o_wb_rd      = wb_q.rd;
    assign o_wb_data    = wb_q.data;
    assign o_next_pc    = wb_q.next_pc;

endmodule

// ==== design/rv64_regfile.sv ====
`timescale 1ns/1ps

`include "rv64_exec_config.svh"

module rv64_regfile (
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  rv64_exec_pkg::reg_addr_t i_rs1_addr,
    input  rv64_exec_pkg::reg_addr_t i_rs2_addr,
    output rv64_exec_pkg::xdata_t    o_rs1_data,
    output rv64_exec_pkg::xdata_t    o_rs2_data,
    input  logic                     i_we,
    input  rv64_exec_pkg::reg_addr_t i_wr_addr,
    input  rv64_exec_pkg::xdata_t    i_wr_data
);

    rv64_exec_pkg::xdata_t regs [`RV_NREGS];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write port.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read ports, no bypass of the current write.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

// ==== flist.f ====
+incdir+design
design/rv64_exec_pkg.sv
design/rv64_decoder.sv
design/rv64_regfile.sv
design/rv64_alu.sv
design/rv64_branch_unit.sv
design/rv64_exec_unit.sv
testbench/rv64_exec_sva.sv
testbench/tb_rv64_exec.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the execute stage testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_rv64_exec -f flist.f -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" sim.log; then
    exit 0
fi
exit 1

// ==== testbench/rv64_exec_sva.sv ====
`timescale 1ns/1ps

module rv64_exec_sva (
    input logic                     clk,
    input logic                     i_rst_n,
    input logic                     i_valid,
    input logic                     i_wb_valid,
    input logic                     i_wb_we,
    input logic                     i_wb_illegal,
    input rv64_exec_pkg::reg_addr_t i_wb_rd,
    input rv64_exec_pkg::xdata_t    i_x0_data
);

    we_needs_valid: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_wb_we |-> i_wb_valid)
        else $error("write enable without write-back valid");

    illegal_blocks_we: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_wb_illegal |-> !i_wb_we)
        else $error("illegal instruction reported with write enable");

    // one cycle of latency, both ways.
    valid_follows: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_valid |=> i_wb_valid)
        else $error("write-back valid missing one cycle after issue");

    no_stray_valid: assert property (@(posedge clk) disable iff (!i_rst_n)
        !i_valid |=> !i_wb_valid)
        else $error("write-back valid without an issued instruction");

    x0_stays_zero: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_wb_we && i_wb_rd == '0) |-> i_x0_data == '0)
        else $error("x0 holds a nonzero value after a write to it");

endmodule

// ==== testbench/tb_rv64_exec.sv ====
`timescale 1ns/1ps

module tb_rv64_exec;

    typedef struct packed {
        logic        we;
        logic        illegal;
        logic [4:0]  rd;
        logic [63:0] data;
        logic [63:0] next_pc;
    } expect_t;

    logic                      clk = 1'b0;
    logic                      i_rst_n;
    logic                      i_valid;
    rv64_exec_pkg::instr_t     i_instr;
    rv64_exec_pkg::pc_t        i_pc;
    logic                      o_wb_valid;
    logic                      o_wb_we;
    logic                      o_wb_illegal;
    rv64_exec_pkg::reg_addr_t  o_wb_rd;
    rv64_exec_pkg::xdata_t     o_wb_data;
    rv64_exec_pkg::pc_t        o_next_pc;

    logic [63:0] model_regs [32];
    expect_t     exp_q [$];
    logic [63:0] pc_r;
    logic        last_valid;
    int          seed;
    int          n_checks;
    int          n_val_err;
    int          n_other_err;

    rv64_exec_unit rv64_exec_unit_i (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_valid      (i_valid),
        .i_instr      (i_instr),
        .i_pc         (i_pc),
        .o_wb_valid   (o_wb_valid),
        .o_wb_we      (o_wb_we),
        .o_wb_illegal (o_wb_illegal),
        .o_wb_rd      (o_wb_rd),
        .o_wb_data    (o_wb_data),
        .o_next_pc    (o_next_pc)
    );

    bind rv64_exec_unit rv64_exec_sva rv64_exec_sva_i (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_valid      (i_valid),
        .i_wb_valid   (o_wb_valid),
        .i_wb_we      (o_wb_we),
        .i_wb_illegal (o_wb_illegal),
        .i_wb_rd      (o_wb_rd),
        .i_x0_data    (rv64_regfile_i.regs[0])
    );

    always #2 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [63:0] calc64(input logic [2:0] f3, input logic alt,
                                           input logic [63:0] a, input logic [63:0] b);
        logic [63:0] r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[5:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'd3: r = (a < b) ? 64'd1 : 64'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) r = $signed(a) >>> b[5:0];
                else     r = a >> b[5:0];
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // word forms sign-extended from bit 31.
    function automatic logic [63:0] calc32(input logic [2:0] f3, input logic alt,
                                           input logic [63:0] a, input logic [63:0] b);
        logic [31:0] w;
        logic [31:0] r;
        w = a[31:0];
        case (f3)
            3'd1: r = w << b[4:0];
            3'd5: begin
                if (alt) r = $signed(w) >>> b[4:0];
                else     r = w >> b[4:0];
            end
            default: r = alt ? w - b[31:0] : w + b[31:0];
        endcase
        return {{32{r[31]}}, r};
    endfunction

    function automatic expect_t predict(input logic [31:0] ins, input logic [63:0] pc);
        expect_t     e;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] imm_i;
        logic [63:0] imm_u;
        logic [63:0] tgt;
        logic        f7_ok;
        logic        taken;
        f3    = ins[14:12];
        f7    = ins[31:25];
        a     = model_regs[ins[19:15]];
        b     = model_regs[ins[24:20]];
        imm_i = {{52{ins[31]}}, ins[31:20]};
        imm_u = {{32{ins[31]}}, ins[31:12], 12'h000};
        f7_ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        taken = 1'b0;
        e         = '0;
        e.rd      = ins[11:7];
        e.we      = 1'b1;
        e.next_pc = pc + 64'd4;
        case (ins[6:0])
            7'h33: begin
                e.illegal = !f7_ok;
                e.data    = calc64(f3, f7[5], a, b);
            end
            7'h13: begin
                if (f3 == 3'd1) e.illegal = ins[31:26] != 6'h00;
                if (f3 == 3'd5) e.illegal = ins[31:26] != 6'h00 && ins[31:26] != 6'h10;
                e.data = calc64(f3, f3 == 3'd5 && ins[30], a, imm_i);
            end
            7'h3b: begin
                e.illegal = !f7_ok || !(f3 inside {3'd0, 3'd1, 3'd5});
                e.data    = calc32(f3, f7[5], a, b);
            end
            7'h1b: begin
                e.illegal = !(f3 inside {3'd0, 3'd1, 3'd5}) || (f3 != 3'd0 && !f7_ok);
                e.data    = calc32(f3, f3 == 3'd5 && ins[30], a, imm_i);
            end
            7'h37: e.data = imm_u;
            7'h17: e.data = pc + imm_u;
            7'h6f: begin
                e.data    = pc + 64'd4;
                e.next_pc = pc + {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'h67: begin
                e.illegal = f3 != 3'd0;
                e.data    = pc + 64'd4;
                tgt       = a + imm_i;
                e.next_pc = {tgt[63:1], 1'b0};
            end
            7'h63: begin
                e.we = 1'b0;
                case (f3)
                    3'd0: taken = a == b;
                    3'd1: taken = a != b;
                    3'd4: taken = $signed(a) < $signed(b);
                    3'd5: taken = $signed(a) >= $signed(b);
                    3'd6: taken = a < b;
                    3'd7: taken = a >= b;
                    default: e.illegal = 1'b1;
                endcase
                if (taken) begin
                    e.next_pc = pc + {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            default: e.illegal = 1'b1;
        endcase
        if (e.illegal) begin
            e.we      = 1'b0;
            e.next_pc = pc + 64'd4;
        end
        return e;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] random_instr();
        logic [31:0] r;
        logic [31:0] ins;
        logic [2:0]  f3;
        r   = $random(seed);
        ins = $random(seed);
        // x0 to x7 only so results feed each other often.
        ins[11:10] = 2'b00;
        ins[19:18] = 2'b00;
        f3 = (r[6:5] == 2'd0) ? 3'd0 : (r[6:5] == 2'd1) ? 3'd1 : 3'd5;
        if (r[4:0] < 5'd6) begin
            ins[6:0]   = 7'h33;
            ins[24:23] = 2'b00;
            ins[31:25] = (r[5] && (ins[14:12] == 3'd0 || ins[14:12] == 3'd5)) ? 7'h20 : 7'h00;
        end else if (r[4:0] < 5'd12) begin
            ins[6:0] = 7'h13;
            if (ins[14:12] == 3'd1) ins[31:26] = 6'h00;
            if (ins[14:12] == 3'd5) ins[31:26] = r[5] ? 6'h10 : 6'h00;
        end else if (r[4:0] < 5'd16) begin
            ins[6:0]   = 7'h3b;
            ins[14:12] = f3;
            ins[24:23] = 2'b00;
            ins[31:25] = (r[7] && f3 != 3'd1) ? 7'h20 : 7'h00;
        end else if (r[4:0] < 5'd20) begin
            ins[6:0]   = 7'h1b;
            ins[14:12] = f3;
            if (f3 != 3'd0) ins[31:25] = (r[7] && f3 == 3'd5) ? 7'h20 : 7'h00;
        end else if (r[4:0] < 5'd22) begin
            ins[6:0] = 7'h37;
        end else if (r[4:0] == 5'd22) begin
            ins[6:0] = 7'h17;
        end else if (r[4:0] == 5'd23) begin
            ins[6:0] = 7'h6f;
        end else if (r[4:0] == 5'd24) begin
            ins[6:0]   = 7'h67;
            ins[14:12] = 3'd0;
        end else if (r[4:0] < 5'd29) begin
            ins[6:0]   = 7'h63;
            ins[24:23] = 2'b00;
            if (ins[13]) ins[14] = 1'b1;
        end else begin
            // multiply, load, csr and bad shift encodings.
            case (r[6:5])
                2'd0: begin
                    ins[6:0]   = 7'h33;
                    ins[31:25] = 7'h01;
                end
                2'd1: ins[6:0] = 7'h03;
                2'd2: ins[6:0] = 7'h73;
                default: begin
                    ins[14:12] = 3'd1;
                    if (r[7]) begin
                        // slliw with a shamt of 32 or more.
                        ins[6:0]   = 7'h1b;
                        ins[31:25] = 7'h01;
                    end else begin
                        ins[6:0]   = 7'h13;
                        ins[31:26] = 6'h20;
                    end
                end
            endcase
        end
        return ins;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            n_val_err++;
        end
    endtask

    task automatic check_outputs();
        expect_t e;
        check_value("o_wb_valid", 64'(o_wb_valid), 64'(last_valid));
        if (!o_wb_valid) begin
            check_value("o_wb_we", 64'(o_wb_we), 64'd0);
            check_value("o_wb_illegal", 64'(o_wb_illegal), 64'd0);
        end else if (exp_q.size() == 0) begin
            $display("write-back valid seen with no instruction outstanding");
            n_other_err++;
        end else begin
            e = exp_q.pop_front();
            check_value("o_wb_we", 64'(o_wb_we), 64'(e.we));
            check_value("o_wb_illegal", 64'(o_wb_illegal), 64'(e.illegal));
            check_value("o_next_pc", o_next_pc, e.next_pc);
            if (e.we) begin
                check_value("o_wb_rd", 64'(o_wb_rd), 64'(e.rd));
                check_value("o_wb_data", o_wb_data, e.data);
            end
        end
    endtask

    // drive on the rising edge and check on the falling edge.
    task automatic step(input logic v, input logic [31:0] ins);
        expect_t e;
        @(posedge clk);
        i_valid <= v;
        i_instr <= ins;
        i_pc    <= pc_r;
        if (v) begin
            e = predict(ins, pc_r);
            exp_q.push_back(e);
            if (e.we && e.rd != 5'd0) model_regs[e.rd] = e.data;
            pc_r = e.next_pc;
        end
        @(negedge clk);
        check_outputs();
        last_valid = v;
    endtask

    task automatic drain_queue();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 16) begin
            step(1'b0, 32'h0000_0000);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timed out waiting for %0d outstanding write-backs", exp_q.size());
            n_other_err++;
        end
    endtask

    initial begin
        logic [31:0] r;
        seed        = 13;
        n_checks    = 0;
        n_val_err   = 0;
        n_other_err = 0;
        last_valid  = 1'b0;
        pc_r        = 64'h0000_0000_8000_0000;
        i_rst_n <= 1'b0;
        i_valid <= 1'b0;
        i_instr <= '0;
        i_pc    <= '0;
        for (int k = 0; k < 32; k++) begin
            model_regs[k] = 64'd0;
        end
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            check_value("o_wb_valid", 64'(o_wb_valid), 64'd0);
            check_value("o_wb_we", 64'(o_wb_we), 64'd0);
            check_value("o_next_pc", o_next_pc, 64'd0);
        end
        @(posedge clk);
        i_rst_n <= 1'b1;
        repeat (3) step(1'b0, 32'h0000_0000);
        // addi xk, xk, 0 shows every register cleared.
        for (int k = 1; k < 32; k++) begin
            step(1'b1, {12'h000, 5'(k), 3'b000, 5'(k), 7'h13});
        end
        for (int n = 0; n < 3000; n++) begin
            r = $random(seed);
            if (r[1:0] == 2'd0) step(1'b0, $random(seed));
            else                step(1'b1, random_instr());
        end
        drain_queue();
        $display("checks %0d, value errors %0d, other errors %0d",
                 n_checks, n_val_err, n_other_err);
        if (n_val_err == 0 && n_other_err == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
